// ==== design/line_pkg.sv ====
package line_pkg;

	// one line code word, sync header in the top two bits.
	typedef logic [9:0] word_t;

	// sync headers.
	localparam logic [1:0] hdr_data = 2'b01;
	localparam logic [1:0] hdr_ctrl = 2'b10;

	// field carried in the low five bits of an idle word.
	localparam logic [4:0] idle_field = 5'b10101;

	// control opcodes, bits 7:5 of a control word.
	typedef enum logic [2:0] {
		ctrl_idle  = 3'b000,
		ctrl_start = 3'b101,
		ctrl_stop  = 3'b110
	} ctrl_op_e;

	// gearbox phases.
	// each is named after the word whose bits go out in that cycle.
	// ph_word3 is the reset and wait phase.
	typedef enum logic [2:0] {
		ph_word3,
		ph_word4,
		ph_word0,
		ph_word1,
		ph_word2
	} gear_phase_e;

endpackage

// ==== design/data_scrambler.sv ====
`timescale 1ns/1ps

module data_scrambler (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           data_strobe,
	input  logic [7:0]     data_byte,
	input  logic           frame_start,
	output line_pkg::word_t data_word,
	output logic           data_word_strobe
);

	import line_pkg::*;

	// lfsr seed for reset and frame start.
	localparam logic [6:0] lfsr_init = 7'h7f;

	logic [6:0] lfsr;
	logic [6:0] lfsr_seed;
	logic [6:0] lfsr_next;
	logic [7:0] key;

	// frame start reloads the lfsr before this cycle's byte is scrambled.
	assign lfsr_seed = frame_start ? lfsr_init : lfsr;

	// eight steps of x^7+x^6+1, first new bit lands in the byte msb.
	always_comb begin
		lfsr_next = lfsr_seed;
		for (int i = 7; i >= 0; i--) begin
			key[i] = lfsr_next[6] ^ lfsr_next[5];
			lfsr_next = {lfsr_next[5:0], key[i]};
		end
	end

	// lfsr and strobe.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr             <= lfsr_init;
			data_word_strobe <= 1'b0;
		end else begin
			data_word_strobe <= data_strobe;
			// only a data byte advances the keystream.
			if (data_strobe) begin
				lfsr <= lfsr_next;
			end else begin
				lfsr <= lfsr_seed;
			end
		end
	end

	// word payload, one cycle after the strobe.
	always_ff @(posedge clk) begin
		if (data_strobe) begin
			data_word <= {hdr_data, data_byte ^ key};
		end
	end

endmodule

// ==== design/frame_ctrl_encoder.sv ====
`timescale 1ns/1ps

module frame_ctrl_encoder (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               data_strobe,
	input  logic               ctrl_strobe,
	input  line_pkg::ctrl_op_e ctrl_op,
	output line_pkg::word_t    ctrl_word,
	output logic               ctrl_word_strobe,
	output logic               frame_start
);

	import line_pkg::*;

	// frame state.
	typedef enum logic {
		st_out,
		st_in
	} frame_state_e;

	frame_state_e state;
	logic [4:0]   byte_count;
	logic [4:0]   ctrl_field;

	// low field of the control word, chosen by opcode.
	always_comb begin
		case (ctrl_op)
			ctrl_start: ctrl_field = 5'd0;
			ctrl_stop:  ctrl_field = byte_count;
			default:    ctrl_field = idle_field;
		endcase
	end

	// frame state, byte count and strobes.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state            <= st_out;
			byte_count       <= 5'd0;
			ctrl_word_strobe <= 1'b0;
			frame_start      <= 1'b0;
		end else begin
			ctrl_word_strobe <= ctrl_strobe;
			frame_start      <= 1'b0;
			// count wraps at 32.
			if (data_strobe && state == st_in) begin
				byte_count <= byte_count + 5'd1;
			end
			if (ctrl_strobe) begin
				case (ctrl_op)
					// a start inside a frame restarts it.
					ctrl_start: begin
						state       <= st_in;
						byte_count  <= 5'd0;
						frame_start <= 1'b1;
					end
					ctrl_stop: begin
						state <= st_out;
					end
					default: begin
						state <= state;
					end
				endcase
			end
		end
	end

	// word payload.
	always_ff @(posedge clk) begin
		if (ctrl_strobe) begin
			ctrl_word <= {hdr_ctrl, ctrl_op, ctrl_field};
		end
	end

endmodule

// ==== design/word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo #(
	parameter int fifo_depth = 8,
	parameter int fill_start = 4
) (
	input  logic            clk,
	input  logic            rst_n,
	input  line_pkg::word_t data_word,
	input  logic            data_word_strobe,
	input  line_pkg::word_t ctrl_word,
	input  logic            ctrl_word_strobe,
	input  logic            fifo_rd_en,
	output line_pkg::word_t fifo_rd_data,
	output logic            fifo_ready,
	output logic            overflow
);

	import line_pkg::*;

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int lvl_w = $clog2(fifo_depth + 1);

	word_t              mem [fifo_depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [lvl_w-1:0]   level;
	word_t              wr_word;
	logic               wr_req;
	logic               empty;
	logic               full;
	logic               do_wr;
	logic               do_rd;

	// circular pointer step.
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(fifo_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// encoders never strobe in the same cycle.
	assign wr_req  = data_word_strobe | ctrl_word_strobe;
	assign wr_word = ctrl_word_strobe ? ctrl_word : data_word;
	assign empty   = (level == '0);
	assign full    = (level == lvl_w'(fifo_depth));
	assign do_rd   = fifo_rd_en & ~empty;
	// a read in the same cycle frees a slot.
	assign do_wr   = wr_req & (~full | do_rd);

	// storage.
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	// pointers, level, flags and read register.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			level        <= '0;
			fifo_ready   <= 1'b0;
			overflow     <= 1'b0;
			fifo_rd_data <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
			// sticky until reset.
			if (level >= lvl_w'(fill_start)) begin
				fifo_ready <= 1'b1;
			end
			// dropped write.
			if (wr_req && !do_wr) begin
				overflow <= 1'b1;
			end
			// empty read gives an idle word.
			if (fifo_rd_en) begin
				fifo_rd_data <= empty ? {hdr_ctrl, ctrl_idle, idle_field} : mem[rd_ptr];
			end
		end
	end

endmodule

// ==== design/gearbox_10to8.sv ====
`timescale 1ns/1ps

module gearbox_10to8 (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            fifo_ready,
	output logic            fifo_rd_en,
	input  line_pkg::word_t fifo_rd_data,
	output logic [7:0]      line_out,
	output logic            line_active
);

	import line_pkg::*;

	gear_phase_e phase;
	// leftover bits of the previous word, left in the low end.
	logic [7:0]  temp_buf;

	// five phases pack four words into five bytes.
	// fifo_rd_en is registered, so a read set up in one phase
	// delivers its word two phases later.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase       <= ph_word3;
			fifo_rd_en  <= 1'b0;
			temp_buf    <= 8'h00;
			line_out    <= 8'h00;
			line_active <= 1'b0;
		end else begin
			case (phase)
				// six bits left plus top two of word 3.
				ph_word3: begin
					line_out <= {temp_buf[5:0], fifo_rd_data[9:8]};
					temp_buf <= fifo_rd_data[7:0];
					// wait here until the fifo has filled.
					if (fifo_ready) begin
						phase      <= ph_word4;
						fifo_rd_en <= 1'b1;
					end else begin
						fifo_rd_en <= 1'b0;
					end
				end
				// rest of word 3, no new word used.
				ph_word4: begin
					line_out   <= temp_buf;
					temp_buf   <= 8'h00;
					fifo_rd_en <= 1'b1;
					phase      <= ph_word0;
				end
				// top eight bits of word 0 start an aligned group.
				ph_word0: begin
					line_out    <= fifo_rd_data[9:2];
					temp_buf    <= {6'd0, fifo_rd_data[1:0]};
					fifo_rd_en  <= 1'b1;
					line_active <= 1'b1;
					phase       <= ph_word1;
				end
				// two left plus six of word 1.
				ph_word1: begin
					line_out   <= {temp_buf[1:0], fifo_rd_data[9:4]};
					temp_buf   <= {4'd0, fifo_rd_data[3:0]};
					fifo_rd_en <= 1'b1;
					phase      <= ph_word2;
				end
				// four left plus six of word 2, skip one read.
				ph_word2: begin
					line_out   <= {temp_buf[3:0], fifo_rd_data[9:6]};
					temp_buf   <= {2'd0, fifo_rd_data[5:0]};
					fifo_rd_en <= 1'b0;
					phase      <= ph_word3;
				end
				default: begin
					fifo_rd_en <= 1'b0;
					phase      <= ph_word3;
				end
			endcase
		end
	end

endmodule

// ==== design/line_coder_top.sv ====
`timescale 1ns/1ps

module line_coder_top #(
	parameter int fifo_depth = 8,
	parameter int fill_start = 4
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               data_strobe,
	input  logic [7:0]         data_byte,
	input  logic               ctrl_strobe,
	input  line_pkg::ctrl_op_e ctrl_op,
	output logic [7:0]         line_out,
	output logic               line_active,
	output logic               overflow
);

	import line_pkg::*;

	// encoder to fifo.
	word_t data_word;
	logic  data_word_strobe;
	word_t ctrl_word;
	logic  ctrl_word_strobe;
	// frame state lives in the control encoder only.
	logic  frame_start;
	// fifo to gearbox.
	word_t fifo_rd_data;
	logic  fifo_rd_en;
	logic  fifo_ready;

	data_scrambler data_scrambler_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.data_strobe      (data_strobe),
		.data_byte        (data_byte),
		.frame_start      (frame_start),
		.data_word        (data_word),
		.data_word_strobe (data_word_strobe)
	);

	frame_ctrl_encoder frame_ctrl_encoder_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.data_strobe      (data_strobe),
		.ctrl_strobe      (ctrl_strobe),
		.ctrl_op          (ctrl_op),
		.ctrl_word        (ctrl_word),
		.ctrl_word_strobe (ctrl_word_strobe),
		.frame_start      (frame_start)
	);

	word_fifo #(
		.fifo_depth (fifo_depth),
		.fill_start (fill_start)
	) word_fifo_inst (
		.clk              (clk),
		.rst_n            (rst_n),
		.data_word        (data_word),
		.data_word_strobe (data_word_strobe),
		.ctrl_word        (ctrl_word),
		.ctrl_word_strobe (ctrl_word_strobe),
		.fifo_rd_en       (fifo_rd_en),
		.fifo_rd_data     (fifo_rd_data),
		.fifo_ready       (fifo_ready),
		.overflow         (overflow)
	);

	gearbox_10to8 gearbox_10to8_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.fifo_ready   (fifo_ready),
		.fifo_rd_en   (fifo_rd_en),
		.fifo_rd_data (fifo_rd_data),
		.line_out     (line_out),
		.line_active  (line_active)
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	// 20 ns period.
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset held for five rising edges, released away from the edge.
	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== verif/line_coder_assertions.sv ====
`timescale 1ns/1ps

module line_coder_assertions (
	input logic                  clk,
	input logic                  rst_n,
	input logic                  data_strobe,
	input logic                  ctrl_strobe,
	input logic [7:0]            line_out,
	input logic                  line_active,
	input logic                  fifo_rd_en,
	input line_pkg::gear_phase_e phase
);

	import line_pkg::*;

	// one operation per cycle at most.
	strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(data_strobe && ctrl_strobe))
		else $error("data and control strobes high in the same cycle");

	// quiet line before alignment.
	line_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!line_active |-> line_out == 8'h00)
		else $error("line_out not zero while line_active is low");

	// line_active is sticky.
	active_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		line_active |=> line_active)
		else $error("line_active fell after rising");

	// rd_en is registered, so the skipped read shows up in ph_word3.
	read_skipped: assert property (@(posedge clk) disable iff (!rst_n)
		phase == ph_word3 |-> !fifo_rd_en)
		else $error("fifo read requested in the skip phase");

endmodule

// ==== verif/line_coder_tb.sv ====
`timescale 1ns/1ps

module line_coder_tb;

	import line_pkg::*;

	// operation kinds.
	localparam int op_data  = 0;
	localparam int op_start = 1;
	localparam int op_stop  = 2;
	// idle word, header 10, opcode 000, field 10101.
	localparam word_t idle_word = 10'h215;

	logic        clk;
	logic        rst_n;
	logic        data_strobe;
	logic [7:0]  data_byte;
	logic        ctrl_strobe;
	ctrl_op_e    ctrl_op;
	logic [7:0]  line_out;
	logic        line_active;
	logic        overflow;

	// stimulus and expected words, one entry per file line.
	int          op_kind[$];
	logic [7:0]  op_value[$];
	bit          op_burst[$];
	word_t       exp_words[$];

	int          errors;
	int          checked;
	int          idle_seen;
	int          cycles;
	int          cycle_limit;
	int          seed;
	int          burst_run;
	bit          run_done;
	logic [39:0] group;
	int          group_bytes;

	tb_clock_gen clock_gen_inst (
		.clk   (clk),
		.rst_n (rst_n)
	);

	line_coder_top #(
		.fifo_depth (8),
		.fill_start (4)
	) line_coder_top_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.data_strobe (data_strobe),
		.data_byte   (data_byte),
		.ctrl_strobe (ctrl_strobe),
		.ctrl_op     (ctrl_op),
		.line_out    (line_out),
		.line_active (line_active),
		.overflow    (overflow)
	);

	bind line_coder_top line_coder_assertions assertions_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.data_strobe (data_strobe),
		.ctrl_strobe (ctrl_strobe),
		.line_out    (line_out),
		.line_active (line_active),
		.fifo_rd_en  (fifo_rd_en),
		.phase       (gearbox_10to8_inst.phase)
	);

	// lines starting with # are comments.
	task automatic read_stimulus();
		int            fd;
		int            code;
		logic [63:0]   kind_s;
		logic [63:0]   pace_s;
		logic [7:0]    value;
		logic [9:0]    expect_w;
		logic [1023:0] rest;
		fd = $fopen("verif/line_coder_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", kind_s);
			if (code != 1) begin
				break;
			end
			if (kind_s == "#") begin
				code = $fgets(rest, fd);
			end else begin
				code = $fscanf(fd, "%h %s %h", value, pace_s, expect_w);
				if (code != 3) begin
					$display("malformed line in the stimulus file");
					errors++;
				end else if (kind_s != "data" && kind_s != "start" && kind_s != "stop") begin
					$display("unknown operation kind in the stimulus file");
					errors++;
				end else begin
					op_kind.push_back(kind_s == "data" ? op_data :
						(kind_s == "start" ? op_start : op_stop));
					op_value.push_back(value);
					op_burst.push_back(pace_s == "burst");
					exp_words.push_back(expect_w);
				end
			end
		end
		$fclose(fd);
	endtask

	// one strobe cycle.
	task automatic apply_op(input int kind, input logic [7:0] value);
		@(posedge clk);
		data_strobe <= (kind == op_data);
		ctrl_strobe <= (kind != op_data);
		if (kind == op_data) begin
			data_byte <= value;
		end else begin
			ctrl_op <= ctrl_op_e'(value[2:0]);
		end
	endtask

	task automatic idle_for(input int n);
		repeat (n) begin
			@(posedge clk);
			data_strobe <= 1'b0;
			ctrl_strobe <= 1'b0;
		end
	endtask

	// idle words are skipped, everything else is matched in order.
	task automatic check_word(input word_t got);
		if (got[9:8] != hdr_data && got[9:8] != hdr_ctrl) begin
			$display("mismatch at %0t: bad sync header in word %h", $time, got);
			errors++;
		end else if (got == idle_word) begin
			idle_seen++;
		end else if (checked >= exp_words.size()) begin
			$display("unexpected extra word %h on the line at %0t", got, $time);
			errors++;
		end else begin
			if (got != exp_words[checked]) begin
				$display("mismatch at %0t: expected %h, got %h", $time,
					exp_words[checked], got);
				errors++;
			end
			checked++;
		end
	endtask

	task automatic finish_run();
		run_done = 1'b1;
		$display("words checked %0d, idle words %0d, errors %0d", checked, idle_seen, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	// five bytes hold four words once aligned.
	always @(negedge clk) begin
		if (line_active) begin
			group = {group[31:0], line_out};
			group_bytes++;
			if (group_bytes == 5) begin
				group_bytes = 0;
				for (int w = 0; w < 4; w++) begin
					check_word(group[39 - 10*w -: 10]);
				end
			end
		end
	end

	// run limit.
	always @(posedge clk) begin
		cycles++;
		if (!run_done && cycles >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d expected words not seen",
				cycles, exp_words.size() - checked);
			errors++;
			finish_run();
		end
	end

	initial begin
		data_strobe = 1'b0;
		data_byte   = 8'h00;
		ctrl_strobe = 1'b0;
		ctrl_op     = ctrl_idle;
		errors      = 0;
		checked     = 0;
		idle_seen   = 0;
		cycles      = 0;
		cycle_limit = 200;
		run_done    = 1'b0;
		group       = '0;
		group_bytes = 0;
		seed        = 66;
		void'($urandom(seed));
		read_stimulus();
		cycle_limit = 40 * op_kind.size() + 200;
		@(posedge rst_n);
		idle_for(2);
		burst_run = 0;
		// paced ops get a random gap, bursts idle one cycle in five.
		foreach (op_kind[i]) begin
			apply_op(op_kind[i], op_value[i]);
			if (op_burst[i]) begin
				burst_run++;
				if (burst_run == 4) begin
					idle_for(1);
					burst_run = 0;
				end
			end else begin
				burst_run = 0;
				idle_for(1 + ($urandom % 4));
			end
		end
		idle_for(1);
		while (checked < exp_words.size()) begin
			@(posedge clk);
		end
		if (overflow) begin
			$display("fifo overflow flag is set at the end of the run");
			errors++;
		end
		if (idle_seen == 0) begin
			$display("no idle words were seen on the line");
			errors++;
		end
		finish_run();
	end

endmodule

// ==== line_coder.f ====
design/line_pkg.sv
design/data_scrambler.sv
design/frame_ctrl_encoder.sv
design/word_fifo.sv
design/gearbox_10to8.sv
design/line_coder_top.sv
verif/tb_clock_gen.sv
verif/line_coder_assertions.sv
verif/line_coder_tb.sv

// ==== Bender.yml ====
package:
  name: line_coder

sources:
  - files:
      - design/line_pkg.sv
      - design/data_scrambler.sv
      - design/frame_ctrl_encoder.sv
      - design/word_fifo.sv
      - design/gearbox_10to8.sv
      - design/line_coder_top.sv
  - target: simulation
    files:
      - verif/tb_clock_gen.sv
      - verif/line_coder_assertions.sv
      - verif/line_coder_tb.sv

// ==== verif/line_coder_stimulus.txt ====
# kind value pacing expected, value and expected word in hex
# value is the data byte, or the opcode for start and stop
data a5 paced 1a7
start 5 paced 2a0
data 11 paced 113
data 22 paced 12e
data 33 paced 11b
stop 6 paced 2c3
data 5a paced 1a8
start 5 burst 2a0
data 00 burst 102
data 01 burst 10d
data 02 burst 12a
data 03 burst 1f1
data 04 burst 128
data 05 burst 1ef
data 06 burst 17b
data 07 burst 109
data 08 burst 12c
data 09 burst 1d3
data 0a burst 1d4
data 0b burst 1cd
data 0c burst 19b
data 0d burst 17e
data 0e burst 124
data 0f burst 1f1
data 10 burst 114
data 11 burst 109
data 12 burst 143
data 13 burst 1f7
data 14 burst 14d
data 15 burst 1c1
data 16 burst 1ec
data 17 burst 10b
data 18 burst 151
data 19 burst 1ac
data 1a burst 1a7
data 1b burst 196
data 1c burst 132
data 1d burst 1fb
data 1e burst 14b
data 1f burst 1e3
data 20 burst 128
stop 6 burst 2c1
